// ==== project.f ====
source/lsu_pkg.sv
source/load_store.sv
source/data_cache.sv
source/main_memory.sv
source/mem_subsystem.sv
+incdir+testbench
testbench/tb_mem_subsystem.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# compile and run the mem_subsystem testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -j 0 \
    -f project.f \
    --top-module tb_mem_subsystem \
    -o tb_sim

./obj_dir/tb_sim 2>&1 | tee sim.log

if grep -q "Simulation finished: FAIL" sim.log; then
    echo "run failed, see sim.log"
    exit 1
fi
if ! grep -q "Simulation finished: PASS" sim.log; then
    echo "run ended without a result, see sim.log"
    exit 1
fi
echo "run passed"

// ==== testbench/tb_checks.svh ====
// concurrent checks of the DUT outputs against the shadow model and timing rules
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

// **************************************************
// reset
// **************************************************

a_reset_quiet: assert property (@(negedge clock) reset |-> !done && !misaligned)
    else report_error("done or misaligned high while reset is asserted");

a_reset_exit: assert property (@(negedge clock)
    !reset && $past(reset) |-> !done && !misaligned && UUT.dcache.state == lsu_pkg::IDLE)
    else report_error("DUT not quiet and idle in the first cycle after reset");

// **************************************************
// results
// **************************************************

a_load_value: assert property (@(negedge clock) disable iff (reset)
    done && check_load |-> result == exp_result)
    else value_mismatch({test_name, " load result"}, exp_result, result);

a_store_data: assert property (@(negedge clock) disable iff (reset)
    done && check_store |-> result == data_2)
    else value_mismatch({test_name, " store result"}, data_2, result);

a_store_addr: assert property (@(negedge clock) disable iff (reset)
    done && check_store |-> result_address == exp_address)
    else value_mismatch({test_name, " store address"}, exp_address, result_address);

// **************************************************
// timing and alignment
// **************************************************

a_repeat_hit: assert property (@(negedge clock) disable iff (reset)
    expect_hit && wait_cycles == 0 |-> done)
    else report_error({test_name, ": repeated load did not hit in the cycle presented"});

a_misaligned_flag: assert property (@(negedge clock) disable iff (reset)
    instr_active && check_misalign |-> misaligned && done)
    else report_error({test_name, ": misaligned access not flagged with done"});

a_aligned_flag: assert property (@(negedge clock) disable iff (reset)
    !check_misalign |-> !misaligned)
    else report_error({test_name, ": aligned access flagged as misaligned"});

a_misaligned_idle: assert property (@(negedge clock) disable iff (reset)
    misaligned |-> !UUT.read && !UUT.write)   // no cache traffic
    else report_error({test_name, ": cache accessed on a misaligned instruction"});

a_idle_no_done: assert property (@(negedge clock) disable iff (reset)
    !instr_active |-> !done)
    else report_error("done raised with no instruction presented");

a_wait_bound: assert property (@(negedge clock) disable iff (reset)
    instr_active |-> wait_cycles <= MAX_WAIT)
    else report_error($sformatf("%s: no done after %0d cycles", test_name, wait_cycles));

`endif

// ==== testbench/tb_mem_subsystem.sv ====
// testbench for mem_subsystem: clock, reset, random instructions, shadow memory, timeout
`timescale 1ns/1ps

module tb_mem_subsystem;

    localparam int CLOCK_PERIOD   = 40;
    localparam int DRIVE_DELAY    = 1;
    localparam int RESET_CYCLES   = 8;
    localparam int RANDOM_SEED    = 90424;
    localparam int NUM_TESTS      = 200;
    localparam int MEM_WORDS      = 256;
    localparam int MEM_LATENCY    = 3;   // DUT default
    localparam int MAX_WAIT       = 2 * MEM_LATENCY + 4;
    localparam int TIMEOUT_CYCLES = NUM_TESTS * (2 * MEM_LATENCY + 6) + RESET_CYCLES;

    logic                     clock;
    logic                     reset;
    lsu_pkg::lsu_op           instr_name;
    logic [lsu_pkg::XLEN-1:0] data_1;
    logic [lsu_pkg::XLEN-1:0] data_2;
    logic [lsu_pkg::XLEN-1:0] immediate;
    logic [lsu_pkg::XLEN-1:0] result;
    logic [lsu_pkg::XLEN-1:0] result_address;
    logic                     done;
    logic                     misaligned;

    logic [31:0] shadow [MEM_WORDS];   // expected memory contents
    logic [31:0] exp_result;
    logic [31:0] exp_address;
    logic        check_load;
    logic        check_store;
    logic        check_misalign;
    logic        expect_hit;
    logic        instr_active;
    int          wait_cycles;
    int          cycle_count;
    int          completed;
    string       test_name;

    mem_subsystem UUT (
        .clock, .reset, .instr_name, .data_1, .data_2, .immediate,
        .result, .result_address, .done, .misaligned
    );

    task automatic abort_run();
        $display("Simulation finished: FAIL");
        $fatal(1, "stopped at first error");
    endtask

    task automatic value_mismatch(input string name, input logic [31:0] expected,
                                  input logic [31:0] actual);
        $display("CHECK FAILED %s: expected 0x%08h, actual 0x%08h", name, expected, actual);
        abort_run();
    endtask

    task automatic report_error(input string what);
        $display("ERROR: %s", what);
        abort_run();
    endtask

    function automatic logic misaligned_access(input lsu_pkg::lsu_op op, input logic [31:0] addr);
        case (op)
            lsu_pkg::LH, lsu_pkg::LHU, lsu_pkg::SH: return addr[0];
            lsu_pkg::LW, lsu_pkg::SW:               return |addr[1:0];
            default:                                return 1'b0;
        endcase
    endfunction

    // lane picked by the low address bits, extended from its top bit
    function automatic logic [31:0] expected_load(input lsu_pkg::lsu_op op,
                                                  input logic [31:0] addr);
        logic [31:0] word;
        logic [7:0]  lane_b;
        logic [15:0] lane_h;
        word   = shadow[addr[9:2]];
        lane_b = word[8*addr[1:0] +: 8];
        lane_h = word[16*addr[1] +: 16];
        case (op)
            lsu_pkg::LB:  return {{24{lane_b[7]}}, lane_b};
            lsu_pkg::LBU: return {24'd0, lane_b};
            lsu_pkg::LH:  return {{16{lane_h[15]}}, lane_h};
            lsu_pkg::LHU: return {16'd0, lane_h};
            default:      return word;
        endcase
    endfunction

    function automatic void apply_store(input lsu_pkg::lsu_op op, input logic [31:0] addr,
                                        input logic [31:0] value);
        case (op)
            lsu_pkg::SB: shadow[addr[9:2]][8*addr[1:0] +: 8]  = value[7:0];
            lsu_pkg::SH: shadow[addr[9:2]][16*addr[1] +: 16] = value[15:0];
            default:     shadow[addr[9:2]] = value;
        endcase
    endfunction

    // **************************************************
    // one instruction, held until done
    // **************************************************

    task automatic run_instruction(input lsu_pkg::lsu_op op, input logic [31:0] base,
                                   input logic [31:0] imm, input logic [31:0] value,
                                   input logic repeat_load);
        logic [31:0] addr;
        addr           = base + imm;
        test_name      = $sformatf("test %0d %s%s addr 0x%0h", completed, op.name(),
                                   repeat_load ? " repeat" : "", addr);
        instr_name     = op;
        data_1         = base;
        data_2         = value;
        immediate      = imm;
        exp_address    = addr;
        check_misalign = misaligned_access(op, addr);
        check_load     = (op inside {lsu_pkg::LB, lsu_pkg::LBU, lsu_pkg::LH, lsu_pkg::LHU,
                                     lsu_pkg::LW}) && !check_misalign;
        check_store    = (op inside {lsu_pkg::SB, lsu_pkg::SH, lsu_pkg::SW}) && !check_misalign;
        expect_hit     = repeat_load;
        exp_result     = expected_load(op, addr);
        wait_cycles    = 0;
        instr_active   = 1'b1;
        @(negedge clock);
        while (!done) begin
            wait_cycles++;
            @(negedge clock);
        end
        if (check_store) begin
            apply_store(op, addr, value);
        end
        completed++;
        @(posedge clock);
        #DRIVE_DELAY;
    endtask

    initial begin
        clock = 1'b0;
        forever #(CLOCK_PERIOD / 2) clock = ~clock;
    end

    always @(posedge clock) begin
        if (cycle_count >= TIMEOUT_CYCLES) begin
            report_error($sformatf("timeout, run still busy after %0d cycles", cycle_count));
        end else begin
            cycle_count++;
        end
    end

    // **************************************************
    // stimulus
    // **************************************************

    initial begin
        lsu_pkg::lsu_op op;
        logic [31:0]    target;
        logic [31:0]    base;
        logic [31:0]    imm;
        logic [31:0]    value;
        logic           last_was_load;
        void'($urandom(RANDOM_SEED));
        reset          = 1'b1;
        instr_name     = lsu_pkg::LW;   // aligned load against the empty cache
        data_1         = '0;
        data_2         = '0;
        immediate      = '0;
        exp_result     = '0;
        exp_address    = '0;
        check_load     = 1'b0;
        check_store    = 1'b0;
        check_misalign = 1'b0;
        expect_hit     = 1'b0;
        instr_active   = 1'b0;
        wait_cycles    = 0;
        cycle_count    = 0;
        completed      = 0;
        last_was_load  = 1'b0;
        op             = lsu_pkg::NOP;
        base           = '0;
        imm            = '0;
        value          = '0;
        for (int w = 0; w < MEM_WORDS; w++) begin
            shadow[w] = {4{8'(w)}};   // same fill as main_memory
        end
        repeat (RESET_CYCLES) @(posedge clock);
        #DRIVE_DELAY;
        reset      = 1'b0;
        instr_name = lsu_pkg::NOP;
        repeat (2) @(posedge clock);
        #DRIVE_DELAY;

        while (completed < NUM_TESTS) begin
            if (last_was_load && $urandom_range(0, 3) == 0) begin
                run_instruction(op, base, imm, value, 1'b1);   // same word, must hit
            end else begin
                op     = lsu_pkg::lsu_op'(4'($urandom_range(0, 7)));
                target = $urandom_range(0, 255);   // first 64 words
                if ($urandom_range(0, 7) != 0) begin
                    if (op inside {lsu_pkg::LH, lsu_pkg::LHU, lsu_pkg::SH}) begin
                        target = target & 32'hFFFF_FFFE;
                    end else if (op inside {lsu_pkg::LW, lsu_pkg::SW}) begin
                        target = target & 32'hFFFF_FFFC;
                    end
                end
                imm   = $urandom_range(0, 127) - 64;
                base  = target - imm;
                value = $urandom();
                run_instruction(op, base, imm, value, 1'b0);
            end
            last_was_load = check_load;
        end

        instr_name   = lsu_pkg::NOP;
        instr_active = 1'b0;
        expect_hit   = 1'b0;
        repeat (2) @(posedge clock);
        if (completed == NUM_TESTS) begin
            $display("Simulation finished: PASS");
            $finish;
        end else begin
            report_error("not every instruction completed");
        end
    end

    `include "tb_checks.svh"

endmodule

// ==== source/mem_subsystem.sv ====
// top level of the load/store path: load_store, data_cache and main_memory
`timescale 1ns/1ps

module mem_subsystem #(
    parameter int NUM_LINES   = 16,
    parameter int MEM_WORDS   = 256,
    parameter int MEM_LATENCY = 3
) (
    input  logic                     clock,
    input  logic                     reset,
    input  lsu_pkg::lsu_op           instr_name,
    input  logic [lsu_pkg::XLEN-1:0] data_1,
    input  logic [lsu_pkg::XLEN-1:0] data_2,
    input  logic [lsu_pkg::XLEN-1:0] immediate,
    output logic [lsu_pkg::XLEN-1:0] result,
    output logic [lsu_pkg::XLEN-1:0] result_address,
    output logic                     done,
    output logic                     misaligned
);

    // **************************************************
    // cache port
    // **************************************************

    logic [lsu_pkg::XLEN-1:0]           address;
    logic [lsu_pkg::XLEN-1:0]           wr_data;
    logic                               read;
    logic                               write;
    logic [lsu_pkg::BYTES_PER_WORD-1:0] write_select;
    logic [lsu_pkg::XLEN-1:0]           rd_data;
    logic                               hit;
    logic                               cache_done;

    // **************************************************
    // memory port
    // **************************************************

    logic                               mem_req;
    logic                               mem_we;
    logic [lsu_pkg::XLEN-1:0]           mem_addr;
    logic [lsu_pkg::XLEN-1:0]           mem_wdata;
    logic [lsu_pkg::BYTES_PER_WORD-1:0] mem_be;
    logic [lsu_pkg::XLEN-1:0]           mem_rdata;
    logic                               mem_ack;

    load_store lsu (
        .instr_name, .data_1, .data_2, .immediate,
        .rd_data, .hit, .cache_done,
        .result, .result_address, .done, .misaligned,
        .address, .wr_data, .read, .write, .write_select
    );

    data_cache #(.NUM_LINES(NUM_LINES)) dcache (
        .clock, .reset,
        .address, .wr_data, .read, .write, .write_select,
        .mem_rdata, .mem_ack,
        .rd_data, .hit, .done(cache_done),
        .mem_req, .mem_we, .mem_addr, .mem_wdata, .mem_be
    );

    main_memory #(.MEM_WORDS(MEM_WORDS), .MEM_LATENCY(MEM_LATENCY)) memory (
        .clock, .reset,
        .mem_req, .mem_we, .mem_addr, .mem_wdata, .mem_be,
        .mem_rdata, .mem_ack
    );

endmodule

// ==== source/main_memory.sv ====
// word-wide backing memory with byte enables and fixed-latency acknowledge
`timescale 1ns/1ps

module main_memory #(
    parameter int MEM_WORDS   = 256,
    parameter int MEM_LATENCY = 3
) (
    input  logic                                clock,
    input  logic                                reset,
    input  logic                                mem_req,
    input  logic                                mem_we,
    input  logic [lsu_pkg::XLEN-1:0]            mem_addr,
    input  logic [lsu_pkg::XLEN-1:0]            mem_wdata,
    input  logic [lsu_pkg::BYTES_PER_WORD-1:0]  mem_be,
    output logic [lsu_pkg::XLEN-1:0]            mem_rdata,
    output logic                                mem_ack
);

    localparam int COUNT_BITS = (MEM_LATENCY > 1) ? $clog2(MEM_LATENCY) : 1;

    logic [lsu_pkg::XLEN-1:0] mem [MEM_WORDS];
    logic [lsu_pkg::XLEN-1:0] word_index;
    logic                     busy;
    logic [COUNT_BITS-1:0]    count;

    assign word_index = (mem_addr >> 2) % MEM_WORDS;
    assign mem_rdata  = mem[word_index];
    assign mem_ack    = busy && (count == '0);

    // latency countdown
    always_ff @(posedge clock) begin
        if (reset) begin
            busy  <= 1'b0;
            count <= '0;
        end else if (!busy) begin
            if (mem_req) begin
                busy  <= 1'b1;
                count <= COUNT_BITS'(MEM_LATENCY - 1);
            end
        end else if (count == '0) begin
            busy <= 1'b0;   // ack cycle
        end else begin
            count <= count - 1'b1;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int w = 0; w < MEM_WORDS; w++) begin
                mem[w] <= 32'h0101_0101 * w;   // known pattern
            end
        end else if (mem_ack && mem_we) begin
            for (int b = 0; b < lsu_pkg::BYTES_PER_WORD; b++) begin
                if (mem_be[b]) begin
                    mem[word_index][8*b +: 8] <= mem_wdata[8*b +: 8];
                end
            end
        end
    end

    a_ack_has_req: assert property (@(posedge clock) disable iff (reset)
        mem_ack |-> mem_req)
        else $error("main_memory: ack without request");

endmodule

// ==== source/data_cache.sv ====
// direct-mapped write-through data cache with one-word lines and fill/write-through FSM
`timescale 1ns/1ps

module data_cache #(
    parameter int NUM_LINES = 16
) (
    input  logic                                clock,
    input  logic                                reset,
    input  logic [lsu_pkg::XLEN-1:0]            address,
    input  logic [lsu_pkg::XLEN-1:0]            wr_data,
    input  logic                                read,
    input  logic                                write,
    input  logic [lsu_pkg::BYTES_PER_WORD-1:0]  write_select,
    input  logic [lsu_pkg::XLEN-1:0]            mem_rdata,
    input  logic                                mem_ack,
    output logic [lsu_pkg::XLEN-1:0]            rd_data,
    output logic                                hit,
    output logic                                done,
    output logic                                mem_req,
    output logic                                mem_we,
    output logic [lsu_pkg::XLEN-1:0]            mem_addr,
    output logic [lsu_pkg::XLEN-1:0]            mem_wdata,
    output logic [lsu_pkg::BYTES_PER_WORD-1:0]  mem_be
);

    localparam int INDEX_BITS = $clog2(NUM_LINES);
    localparam int TAG_BITS   = lsu_pkg::XLEN - INDEX_BITS - 2;

    lsu_pkg::cache_state                state;
    logic [NUM_LINES-1:0]               valid;
    logic [TAG_BITS-1:0]                tag_mem  [NUM_LINES];
    logic [lsu_pkg::XLEN-1:0]           data_mem [NUM_LINES];

    logic [INDEX_BITS-1:0]              index;
    logic [TAG_BITS-1:0]                tag;
    logic [lsu_pkg::XLEN-1:0]           req_addr;
    logic [lsu_pkg::XLEN-1:0]           req_data;
    logic [lsu_pkg::BYTES_PER_WORD-1:0] req_be;
    logic [INDEX_BITS-1:0]              req_index;
    logic [TAG_BITS-1:0]                req_tag;
    logic                               req_hit;
    logic                               start_req;

    // **************************************************
    // lookup
    // **************************************************

    assign index   = address[2 +: INDEX_BITS];
    assign tag     = address[lsu_pkg::XLEN-1 -: TAG_BITS];
    assign rd_data = data_mem[index];
    assign hit     = valid[index] && (tag_mem[index] == tag);

    assign req_index = req_addr[2 +: INDEX_BITS];
    assign req_tag   = req_addr[lsu_pkg::XLEN-1 -: TAG_BITS];
    assign req_hit   = valid[req_index] && (tag_mem[req_index] == req_tag);

    assign start_req = (state == lsu_pkg::IDLE) && (write || (read && !hit));

    // memory port, held for the whole request
    assign mem_req   = (state != lsu_pkg::IDLE);
    assign mem_we    = (state == lsu_pkg::WRITE_THROUGH);
    assign mem_addr  = req_addr;
    assign mem_wdata = req_data;
    assign mem_be    = req_be;

    // **************************************************
    // controller
    // **************************************************

    always_ff @(posedge clock) begin
        if (reset) begin
            state <= lsu_pkg::IDLE;
            done  <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                lsu_pkg::IDLE: begin
                    if (write) begin
                        state <= lsu_pkg::WRITE_THROUGH;   // every store goes out
                    end else if (read && !hit) begin
                        state <= lsu_pkg::FILL;
                    end
                end
                lsu_pkg::FILL: begin
                    if (mem_ack) begin
                        state <= lsu_pkg::IDLE;   // lookup hits next cycle
                    end
                end
                lsu_pkg::WRITE_THROUGH: begin
                    if (mem_ack) begin
                        state <= lsu_pkg::IDLE;
                        done  <= 1'b1;
                    end
                end
                default: state <= lsu_pkg::IDLE;
            endcase
        end
    end

    // request capture
    always_ff @(posedge clock) begin
        if (start_req) begin
            req_addr <= {address[lsu_pkg::XLEN-1:2], 2'b00};
            req_data <= wr_data;
            req_be   <= write ? write_select : '1;
        end
    end

    // **************************************************
    // arrays
    // **************************************************

    always_ff @(posedge clock) begin
        if (reset) begin
            valid <= '0;
        end else if (state == lsu_pkg::FILL && mem_ack) begin
            valid[req_index] <= 1'b1;
        end
    end

    always_ff @(posedge clock) begin
        if (state == lsu_pkg::FILL && mem_ack) begin
            data_mem[req_index] <= mem_rdata;
            tag_mem[req_index]  <= req_tag;
        end else if (state == lsu_pkg::WRITE_THROUGH && mem_ack && req_hit) begin
            for (int b = 0; b < lsu_pkg::BYTES_PER_WORD; b++) begin
                if (req_be[b]) begin
                    data_mem[req_index][8*b +: 8] <= req_data[8*b +: 8];   // merge
                end
            end
        end
    end

    // write wins in IDLE, so a read presented with it would be lost
    a_one_access: assert property (@(posedge clock) disable iff (reset)
        !(read && write))
        else $error("data_cache: read and write requested together");

    a_req_held: assert property (@(posedge clock) disable iff (reset)
        mem_req && !mem_ack |=> mem_req && $stable(mem_addr) && $stable(mem_we))
        else $error("data_cache: memory request dropped before ack");

    a_done_pulse: assert property (@(posedge clock) disable iff (reset)
        done |=> !done)
        else $error("data_cache: done longer than one cycle");

endmodule

// ==== source/load_store.sv ====
// load/store unit: address generation, lane select, extension, byte enables, alignment
`timescale 1ns/1ps

module load_store (
    input  lsu_pkg::lsu_op                      instr_name,
    input  logic [lsu_pkg::XLEN-1:0]            data_1,
    input  logic [lsu_pkg::XLEN-1:0]            data_2,
    input  logic [lsu_pkg::XLEN-1:0]            immediate,
    input  logic [lsu_pkg::XLEN-1:0]            rd_data,
    input  logic                                hit,
    input  logic                                cache_done,
    output logic [lsu_pkg::XLEN-1:0]            result,
    output logic [lsu_pkg::XLEN-1:0]            result_address,
    output logic                                done,
    output logic                                misaligned,
    output logic [lsu_pkg::XLEN-1:0]            address,
    output logic [lsu_pkg::XLEN-1:0]            wr_data,
    output logic                                read,
    output logic                                write,
    output logic [lsu_pkg::BYTES_PER_WORD-1:0]  write_select
);

    logic [lsu_pkg::XLEN-1:0]           eff_addr;
    logic [1:0]                         offset;
    logic                               is_load;
    logic                               is_store;
    logic                               bad_align;
    logic [7:0]                         lane_byte;
    logic [15:0]                        lane_half;
    logic [lsu_pkg::BYTES_PER_WORD-1:0] be_base;
    logic [lsu_pkg::XLEN-1:0]           store_data;

    assign eff_addr = data_1 + immediate;
    assign offset   = eff_addr[1:0];

    // **************************************************
    // decode
    // **************************************************

    always_comb begin
        is_load    = 1'b0;
        is_store   = 1'b0;
        bad_align  = 1'b0;
        be_base    = '0;
        store_data = data_2;
        case (instr_name)
            lsu_pkg::LB, lsu_pkg::LBU: is_load = 1'b1;
            lsu_pkg::LH, lsu_pkg::LHU: begin
                is_load   = 1'b1;
                bad_align = offset[0];
            end
            lsu_pkg::LW: begin
                is_load   = 1'b1;
                bad_align = |offset;
            end
            lsu_pkg::SB: begin
                is_store   = 1'b1;
                be_base    = 'b1;
                store_data = {lsu_pkg::BYTES_PER_WORD{data_2[7:0]}};   // copy to all lanes
            end
            lsu_pkg::SH: begin
                is_store   = 1'b1;
                bad_align  = offset[0];
                be_base    = 'b11;
                store_data = {(lsu_pkg::BYTES_PER_WORD / 2){data_2[15:0]}};
            end
            lsu_pkg::SW: begin
                is_store  = 1'b1;
                bad_align = |offset;
                be_base   = '1;
            end
            default: ;   // NOP
        endcase
    end

    // load lanes
    always_comb begin
        case (offset)
            2'd0:    lane_byte = rd_data[7:0];
            2'd1:    lane_byte = rd_data[15:8];
            2'd2:    lane_byte = rd_data[23:16];
            default: lane_byte = rd_data[31:24];
        endcase
        lane_half = offset[1] ? rd_data[31:16] : rd_data[15:0];
    end

    // **************************************************
    // feed and cache outputs
    // **************************************************

    always_comb begin
        result         = '0;
        result_address = '0;
        done           = 1'b0;
        misaligned     = 1'b0;
        address        = '0;
        wr_data        = '0;
        read           = 1'b0;
        write          = 1'b0;
        write_select   = '0;
        if (bad_align) begin
            misaligned     = 1'b1;   // no cache activity
            done           = 1'b1;
            result_address = eff_addr;
        end else if (is_load) begin
            address = eff_addr;
            read    = 1'b1;
            done    = hit;
            case (instr_name)
                lsu_pkg::LB:  result = {{(lsu_pkg::XLEN-8){lane_byte[7]}}, lane_byte};
                lsu_pkg::LBU: result = {{(lsu_pkg::XLEN-8){1'b0}}, lane_byte};
                lsu_pkg::LH:  result = {{(lsu_pkg::XLEN-16){lane_half[15]}}, lane_half};
                lsu_pkg::LHU: result = {{(lsu_pkg::XLEN-16){1'b0}}, lane_half};
                default:      result = rd_data;
            endcase
        end else if (is_store) begin
            if (cache_done) begin
                result         = data_2;
                result_address = eff_addr;
                done           = 1'b1;
            end else begin
                address      = eff_addr;
                wr_data      = store_data;
                write        = 1'b1;
                write_select = be_base << offset;   // shift to addressed lane
            end
        end
    end

endmodule

// ==== source/lsu_pkg.sv ====
// shared widths, instruction opcodes and cache controller states
package lsu_pkg;

    // **************************************************
    // widths
    // **************************************************

    localparam int XLEN           = 32;   // data and address width
    localparam int BYTES_PER_WORD = 4;    // byte enables per word

    // **************************************************
    // memory instruction opcodes
    // **************************************************

    typedef enum logic [3:0] {
        LB  = 4'd0,   // load byte, signed
        LBU = 4'd1,   // load byte, unsigned
        LH  = 4'd2,   // load halfword, signed
        LHU = 4'd3,   // load halfword, unsigned
        LW  = 4'd4,   // load word
        SB  = 4'd5,   // store byte
        SH  = 4'd6,   // store halfword
        SW  = 4'd7,   // store word
        NOP = 4'd8    // no memory instruction
    } lsu_op;

    // **************************************************
    // data cache controller
    // **************************************************

    typedef enum logic [1:0] {
        IDLE          = 2'd0,   // lookup only
        FILL          = 2'd1,   // read miss, waiting on memory
        WRITE_THROUGH = 2'd2    // store, waiting on memory
    } cache_state;

endpackage
